// ==== hdl/classifier_settings.svh ====
`ifndef CLASSIFIER_SETTINGS_SVH
`define CLASSIFIER_SETTINGS_SVH

// ============================================================
// Classifier widths and latencies
// ============================================================

// Flow key width
`define CLS_KEY_W 32

// Bucket address width, 16 buckets per table
`define CLS_HT_AW 4

// Bucket memory read latency in cycles
`define CLS_RD_LAT 2

`endif

// ==== hdl/classifier_pkg.sv ====
`default_nettype none

`include "classifier_settings.svh"

package classifier_pkg;

    // ============================================================
    // Vector types
    // ============================================================

    typedef logic [`CLS_KEY_W-1:0] key_t;
    typedef logic [`CLS_HT_AW-1:0] bkt_addr_t;
    // MSB picks the table, low bits are the bucket
    typedef logic [`CLS_HT_AW:0]   vid_t;

    // One table entry
    typedef struct packed {
        logic valid;
        key_t key;
    } slot_t;

    typedef enum logic [1:0] {
        OP_LOOKUP,
        OP_INSERT,
        OP_REMOVE
    } cls_op_t;

    // Request as it travels from FSM to hash and back
    typedef struct packed {
        cls_op_t   op;
        key_t      key;
        bkt_addr_t h1;
        bkt_addr_t h2;
    } cls_req_t;

    // Registered compare results
    typedef struct packed {
        logic hit;
        vid_t hit_vid;
        logic t1_free;
        logic t2_free;
    } cls_cmp_t;

    // Shared result bundle for all three operations
    typedef struct packed {
        logic done;
        logic hit_miss;
        logic err;
        vid_t vid;
    } cls_rslt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HASH,
        ST_READ,
        ST_CMP,
        ST_DONE
    } cls_state_t;

endpackage

`default_nettype wire

// ==== hdl/class_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module class_ctrl_fsm
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lu_vld,
    input  logic                   ins_vld,
    input  logic                   rm_vld,
    input  classifier_pkg::key_t     key,
    input  classifier_pkg::cls_req_t hashed,
    input  logic                   expired,
    input  classifier_pkg::cls_cmp_t cmp,
    output logic                   hash_start,
    output classifier_pkg::cls_req_t req,
    output logic                   rd_en,
    output logic                   load,
    output logic                   wr_en,
    output classifier_pkg::vid_t     wr_vid,
    output classifier_pkg::slot_t    wr_slot,
    output logic                   busy,
    output classifier_pkg::cls_rslt_t rslt
);

    import classifier_pkg::*;

    cls_state_t state;
    cls_state_t state_nxt;
    logic [1:0] n_strb;
    logic       accept;
    logic       multi;
    // Accepted request waiting for its first state
    logic       acc_q;
    // Accepted request had conflicting strobes
    logic       multi_q;
    cls_op_t    op_in;

    // ============================================================
    // Strobe check
    // ============================================================

    assign n_strb = 2'(lu_vld) + 2'(ins_vld) + 2'(rm_vld);
    assign multi  = (n_strb > 2'd1);
    // Only sampled when idle and nothing pending
    assign accept = (state == ST_IDLE) && !acc_q && (n_strb != 2'd0);
    assign op_in  = ins_vld ? OP_INSERT : (rm_vld ? OP_REMOVE : OP_LOOKUP);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            acc_q   <= 1'b0;
            multi_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            acc_q <= accept;
            if (accept)
                multi_q <= multi;
        end
    end

    // Request payload, hash fields filled later
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req.op  <= op_in;
            req.key <= key;
            req.h1  <= '0;
            req.h2  <= '0;
        end
    end

    // ============================================================
    // Next state
    // ============================================================

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (acc_q) state_nxt = multi_q ? ST_DONE : ST_HASH;
            ST_HASH: state_nxt = ST_READ;
            ST_READ: state_nxt = ST_CMP;
            // Hold until the slots have come out of the memory
            ST_CMP:  if (expired) state_nxt = ST_DONE;
            ST_DONE: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign hash_start = (state == ST_HASH);
    assign rd_en      = (state == ST_READ);
    assign load       = (state == ST_READ);
    assign busy       = (state != ST_IDLE);

    // ============================================================
    // Decision and table write
    // ============================================================

    always_comb
    begin
        rslt    = '0;
        wr_en   = 1'b0;
        wr_vid  = '0;
        wr_slot = '0;
        rslt.done = (state == ST_DONE);
        if (state == ST_DONE)
        begin
            if (multi_q)
                rslt.err = 1'b1;
            else if (hashed.op == OP_INSERT)
            begin
                if (cmp.hit)
                begin
                    // Already stored, report where
                    rslt.hit_miss = 1'b1;
                    rslt.vid      = cmp.hit_vid;
                end
                else if (cmp.t1_free || cmp.t2_free)
                begin
                    // T1 first, T2 as second choice
                    wr_en         = 1'b1;
                    wr_vid        = cmp.t1_free ? {1'b0, hashed.h1} : {1'b1, hashed.h2};
                    wr_slot.valid = 1'b1;
                    wr_slot.key   = hashed.key;
                    rslt.vid      = wr_vid;
                end
                else
                    rslt.err = 1'b1;
            end
            else if (hashed.op == OP_REMOVE)
            begin
                if (cmp.hit)
                begin
                    // Clear the matching slot
                    wr_en         = 1'b1;
                    wr_vid        = cmp.hit_vid;
                    rslt.hit_miss = 1'b1;
                    rslt.vid      = cmp.hit_vid;
                end
            end
            else
            begin
                rslt.hit_miss = cmp.hit;
                rslt.vid      = cmp.hit_vid;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/class_wait_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module class_wait_timer
(
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    output logic expired
);

    // Counter wide enough for the read latency
    localparam int CNT_W = $clog2(`CLS_RD_LAT + 1);

    logic [CNT_W-1:0] cnt;
    logic             run;

    // Load on the read strobe, count down to zero, then stop
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run <= 1'b0;
            cnt <= '0;
        end
        else if (load)
        begin
            run <= 1'b1;
            cnt <= CNT_W'(`CLS_RD_LAT - 1);
        end
        else if (run)
        begin
            if (cnt == '0)
                run <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    // Lines up with the last memory read stage
    assign expired = run && (cnt == '0);

endmodule

`default_nettype wire

// ==== hdl/class_hash.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module class_hash
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     hash_start,
    input  classifier_pkg::cls_req_t req_in,
    output classifier_pkg::cls_req_t req_out
);

    import classifier_pkg::*;

    bkt_addr_t  h1;
    bkt_addr_t  h2;
    logic [7:0] byte_sum;

    // ============================================================
    // Bucket hashes
    // ============================================================

    always_comb
    begin
        h1       = '0;
        byte_sum = '0;
        // XOR of all nibbles
        for (int i = 0; i < `CLS_KEY_W / `CLS_HT_AW; i++)
            h1 = h1 ^ req_in.key[i*`CLS_HT_AW +: `CLS_HT_AW];
        // Byte sum, low bits kept
        for (int j = 0; j < `CLS_KEY_W / 8; j++)
            byte_sum = byte_sum + req_in.key[j*8 +: 8];
        h2 = byte_sum[`CLS_HT_AW-1:0];
    end

    // Request passes on with both bucket addresses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            req_out <= '0;
        else if (hash_start)
        begin
            req_out.op  <= req_in.op;
            req_out.key <= req_in.key;
            req_out.h1  <= h1;
            req_out.h2  <= h2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/class_bucket_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module class_bucket_mem
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_en,
    input  classifier_pkg::bkt_addr_t h1,
    input  classifier_pkg::bkt_addr_t h2,
    input  logic                      wr_en,
    input  classifier_pkg::vid_t      wr_vid,
    input  classifier_pkg::slot_t     wr_slot,
    output classifier_pkg::slot_t     t1_slot,
    output classifier_pkg::slot_t     t2_slot
);

    import classifier_pkg::*;

    localparam int DEPTH = 2 ** `CLS_HT_AW;

    // Valid bits separate so they can be cleared
    logic [DEPTH-1:0] t1_vld;
    logic [DEPTH-1:0] t2_vld;
    key_t             t1_key [DEPTH];
    key_t             t2_key [DEPTH];
    slot_t            t1_pipe [`CLS_RD_LAT];
    slot_t            t2_pipe [`CLS_RD_LAT];
    bkt_addr_t        wr_addr;

    assign wr_addr = wr_vid[`CLS_HT_AW-1:0];

    // ============================================================
    // Write port, MSB of the VID picks the table
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            t1_vld <= '0;
            t2_vld <= '0;
        end
        else if (wr_en)
        begin
            if (wr_vid[`CLS_HT_AW])
                t2_vld[wr_addr] <= wr_slot.valid;
            else
                t1_vld[wr_addr] <= wr_slot.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en && wr_vid[`CLS_HT_AW])
            t2_key[wr_addr] <= wr_slot.key;
        if (wr_en && !wr_vid[`CLS_HT_AW])
            t1_key[wr_addr] <= wr_slot.key;
    end

    // ============================================================
    // Read pipeline
    // ============================================================

    always_ff @(posedge clk)
    begin
        // First stage samples the arrays
        if (rd_en)
        begin
            t1_pipe[0] <= {t1_vld[h1], t1_key[h1]};
            t2_pipe[0] <= {t2_vld[h2], t2_key[h2]};
        end
        for (int i = 1; i < `CLS_RD_LAT; i++)
        begin
            t1_pipe[i] <= t1_pipe[i-1];
            t2_pipe[i] <= t2_pipe[i-1];
        end
    end

    assign t1_slot = t1_pipe[`CLS_RD_LAT-1];
    assign t2_slot = t2_pipe[`CLS_RD_LAT-1];

endmodule

`default_nettype wire

// ==== hdl/class_key_comp.sv ====
`timescale 1ns/1ns
`default_nettype none

module class_key_comp
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  classifier_pkg::key_t      key,
    input  classifier_pkg::bkt_addr_t h1,
    input  classifier_pkg::bkt_addr_t h2,
    input  classifier_pkg::slot_t     t1_slot,
    input  classifier_pkg::slot_t     t2_slot,
    input  logic                      expired,
    output classifier_pkg::cls_cmp_t  cmp
);

    import classifier_pkg::*;

    logic     t1_hit;
    logic     t2_hit;
    cls_cmp_t cmp_nxt;

    // Only a valid slot can match
    assign t1_hit = t1_slot.valid && (t1_slot.key == key);
    assign t2_hit = t2_slot.valid && (t2_slot.key == key);

    always_comb
    begin
        cmp_nxt.hit     = t1_hit || t2_hit;
        // T1 wins if both match
        if (t1_hit)
            cmp_nxt.hit_vid = {1'b0, h1};
        else if (t2_hit)
            cmp_nxt.hit_vid = {1'b1, h2};
        else
            cmp_nxt.hit_vid = '0;
        cmp_nxt.t1_free = !t1_slot.valid;
        cmp_nxt.t2_free = !t2_slot.valid;
    end

    // Captured once, when the read data is valid
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cmp <= '0;
        else if (expired)
            cmp <= cmp_nxt;
    end

endmodule

`default_nettype wire

// ==== hdl/classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module classifier
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lu_vld,
    input  logic                      ins_vld,
    input  logic                      rm_vld,
    input  classifier_pkg::key_t      key,
    output logic                      busy,
    output classifier_pkg::cls_rslt_t rslt
);

    import classifier_pkg::*;

    // ============================================================
    // Internal wiring
    // ============================================================

    // FSM to hash and back
    logic     hash_start;
    cls_req_t req;
    cls_req_t hashed;

    // Memory read and timer
    logic     rd_en;
    logic     load;
    logic     expired;
    slot_t    t1_slot;
    slot_t    t2_slot;

    // Table write from the FSM
    logic     wr_en;
    vid_t     wr_vid;
    slot_t    wr_slot;

    cls_cmp_t cmp;

    class_ctrl_fsm i_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .lu_vld     (lu_vld),
        .ins_vld    (ins_vld),
        .rm_vld     (rm_vld),
        .key        (key),
        .hashed     (hashed),
        .expired    (expired),
        .cmp        (cmp),
        .hash_start (hash_start),
        .req        (req),
        .rd_en      (rd_en),
        .load       (load),
        .wr_en      (wr_en),
        .wr_vid     (wr_vid),
        .wr_slot    (wr_slot),
        .busy       (busy),
        .rslt       (rslt)
    );

    class_wait_timer i_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .expired (expired)
    );

    class_hash i_hash (
        .clk        (clk),
        .rst_n      (rst_n),
        .hash_start (hash_start),
        .req_in     (req),
        .req_out    (hashed)
    );

    // Addresses come from the hashed request
    class_bucket_mem i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (rd_en),
        .h1      (hashed.h1),
        .h2      (hashed.h2),
        .wr_en   (wr_en),
        .wr_vid  (wr_vid),
        .wr_slot (wr_slot),
        .t1_slot (t1_slot),
        .t2_slot (t2_slot)
    );

    class_key_comp i_cmp (
        .clk     (clk),
        .rst_n   (rst_n),
        .key     (hashed.key),
        .h1      (hashed.h1),
        .h2      (hashed.h2),
        .t1_slot (t1_slot),
        .t2_slot (t2_slot),
        .expired (expired),
        .cmp     (cmp)
    );

endmodule

`default_nettype wire

// ==== bench/classifier_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module classifier_props
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      lu_vld,
    input logic                      ins_vld,
    input logic                      rm_vld,
    input logic                      busy,
    input classifier_pkg::cls_rslt_t rslt
);

    import classifier_pkg::*;

    logic [1:0] n_strb;
    logic       accept;
    // Strobe taken on the previous edge
    logic       acc_d;
    logic       multi_d;
    // Accepted operation still waiting for its done
    logic       op_open;
    int         fail_cnt = 0;

    // ============================================================
    // Acceptance seen from the top-level ports
    // ============================================================

    assign n_strb = 2'(lu_vld) + 2'(ins_vld) + 2'(rm_vld);
    assign accept = !busy && !acc_d && (n_strb != 2'd0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc_d   <= 1'b0;
            multi_d <= 1'b0;
            op_open <= 1'b0;
        end
        else
        begin
            acc_d <= accept;
            if (accept)
                multi_d <= (n_strb > 2'd1);
            if (acc_d)
                op_open <= 1'b1;
            else if (rslt.done)
                op_open <= 1'b0;
        end
    end

    // ============================================================
    // Control timing
    // ============================================================

    // Single-cycle done pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rslt.done |=> !rslt.done)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("done held for more than one cycle");
    end

    // Fixed latency of a normal operation
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d && !multi_d |-> ##5 rslt.done)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("done not seen five cycles after acceptance");
    end

    // Strobe conflict answers in the cycle after edge 1
    multi_err: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d && multi_d |=> rslt.done && rslt.err)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("strobe conflict did not give an error on the next cycle");
    end

    busy_after_reset: assert property (@(posedge clk)
        !rst_n |=> !busy)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("busy high after reset");
    end

    done_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        rslt.done |-> op_open)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("done without an accepted operation");
    end

endmodule

bind classifier classifier_props i_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .lu_vld  (lu_vld),
    .ins_vld (ins_vld),
    .rm_vld  (rm_vld),
    .busy    (busy),
    .rslt    (rslt)
);

`default_nettype wire

// ==== bench/classifier_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module classifier_tb;

    import classifier_pkg::*;

    // Operation count sets the cycle budget
    localparam int N_OPS       = 57;
    localparam int TIMEOUT_CYC = 8 * N_OPS + 50;
    localparam int DEPTH       = 2 ** `CLS_HT_AW;

    logic      clk;
    logic      rst_n;
    logic      lu_vld;
    logic      ins_vld;
    logic      rm_vld;
    key_t      key;
    logic      busy;
    cls_rslt_t rslt;

    // Reference copy of T1 and T2
    slot_t     m_t1 [DEPTH];
    slot_t     m_t2 [DEPTH];
    key_t      pool [8];
    integer    seed;
    int        cycle_cnt;

    classifier i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .lu_vld  (lu_vld),
        .ins_vld (ins_vld),
        .rm_vld  (rm_vld),
        .key     (key),
        .busy    (busy),
        .rslt    (rslt)
    );

    always #10 clk = ~clk;

    // ============================================================
    // Run limit and bound assertion watch
    // ============================================================

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Checks failed");
            $fatal(1);
        end
    end

    always @(posedge clk)
    begin
        if (i_dut.i_props.fail_cnt != 0)
        begin
            $display("A bound timing assertion failed at %0t ns", $time);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_vid(input vid_t got, input vid_t exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // ============================================================
    // Reference model
    // ============================================================

    // XOR of the eight nibbles
    function automatic bkt_addr_t bucket1_of(input key_t k);
        bkt_addr_t h;
        h = '0;
        for (int i = 0; i < 8; i++)
            h = h ^ k[4*i +: 4];
        return h;
    endfunction

    // Byte sum, low nibble
    function automatic bkt_addr_t bucket2_of(input key_t k);
        logic [7:0] s;
        s = k[7:0] + k[15:8] + k[23:16] + k[31:24];
        return s[3:0];
    endfunction

    // Predicts the result and updates the model tables
    task automatic predict_op(input cls_op_t op, input key_t k,
                              output logic e_hit, output logic e_err, output vid_t e_vid);
        bkt_addr_t b1;
        bkt_addr_t b2;
        logic      in1;
        logic      in2;
        b1    = bucket1_of(k);
        b2    = bucket2_of(k);
        in1   = m_t1[b1].valid && (m_t1[b1].key == k);
        in2   = m_t2[b2].valid && (m_t2[b2].key == k);
        e_hit = in1 || in2;
        e_err = 1'b0;
        e_vid = in1 ? {1'b0, b1} : (in2 ? {1'b1, b2} : '0);
        if (op == OP_INSERT && !e_hit)
        begin
            // First free choice, T1 before T2
            if (!m_t1[b1].valid)
            begin
                m_t1[b1] = {1'b1, k};
                e_vid    = {1'b0, b1};
            end
            else if (!m_t2[b2].valid)
            begin
                m_t2[b2] = {1'b1, k};
                e_vid    = {1'b1, b2};
            end
            else
                e_err = 1'b1;
        end
        else if (op == OP_REMOVE && in1)
            m_t1[b1].valid = 1'b0;
        else if (op == OP_REMOVE && in2)
            m_t2[b2].valid = 1'b0;
    endtask

    // ============================================================
    // Operation tasks
    // ============================================================

    task automatic exec_op(input cls_op_t op, input key_t k);
        logic e_hit;
        logic e_err;
        vid_t e_vid;
        predict_op(op, k, e_hit, e_err, e_vid);
        key     = k;
        lu_vld  = (op == OP_LOOKUP);
        ins_vld = (op == OP_INSERT);
        rm_vld  = (op == OP_REMOVE);
        @(posedge clk);
        #2;
        lu_vld  = 1'b0;
        ins_vld = 1'b0;
        rm_vld  = 1'b0;
        // Quiet until the fifth edge
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_flag(rslt.done, 1'b0, "early done");
        end
        @(posedge clk);
        #2;
        check_flag(rslt.done, 1'b1, "done");
        check_flag(rslt.hit_miss, e_hit, "hit_miss");
        check_flag(rslt.err, e_err, "err");
        check_vid(rslt.vid, e_vid, "vid");
        @(posedge clk);
        #2;
        check_flag(busy, 1'b0, "busy after done");
    endtask

    task automatic do_lookup(input key_t k);
        exec_op(OP_LOOKUP, k);
    endtask

    task automatic do_insert(input key_t k);
        exec_op(OP_INSERT, k);
    endtask

    task automatic do_remove(input key_t k);
        exec_op(OP_REMOVE, k);
    endtask

    // Lookup and insert strobes together
    task automatic multi_strobe(input key_t k);
        key     = k;
        lu_vld  = 1'b1;
        ins_vld = 1'b1;
        @(posedge clk);
        #2;
        lu_vld  = 1'b0;
        ins_vld = 1'b0;
        @(posedge clk);
        #2;
        check_flag(rslt.done, 1'b1, "conflict done");
        check_flag(rslt.err, 1'b1, "conflict err");
        check_flag(rslt.hit_miss, 1'b0, "conflict hit_miss");
        @(posedge clk);
        #2;
        check_flag(rslt.done, 1'b0, "conflict done length");
        check_flag(busy, 1'b0, "busy after conflict");
    endtask

    // Lookup of k with an insert strobe of other in the middle
    task automatic strobe_while_busy(input key_t k, input key_t other);
        logic e_hit;
        logic e_err;
        vid_t e_vid;
        predict_op(OP_LOOKUP, k, e_hit, e_err, e_vid);
        key    = k;
        lu_vld = 1'b1;
        @(posedge clk);
        #2;
        lu_vld = 1'b0;
        repeat (2)
            @(posedge clk);
        #2;
        check_flag(busy, 1'b1, "busy during operation");
        key     = other;
        ins_vld = 1'b1;
        @(posedge clk);
        #2;
        ins_vld = 1'b0;
        key     = k;
        repeat (2)
            @(posedge clk);
        #2;
        check_flag(rslt.done, 1'b1, "done with ignored strobe");
        check_flag(rslt.hit_miss, e_hit, "hit_miss with ignored strobe");
        check_vid(rslt.vid, e_vid, "vid with ignored strobe");
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_flag(rslt.done, 1'b0, "extra done from ignored strobe");
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        int pick;
        int sel;
        clk       = 1'b0;
        rst_n     = 1'b0;
        lu_vld    = 1'b0;
        ins_vld   = 1'b0;
        rm_vld    = 1'b0;
        key       = '0;
        cycle_cnt = 0;
        seed      = 32'h1515;
        for (int i = 0; i < DEPTH; i++)
        begin
            m_t1[i] = '0;
            m_t2[i] = '0;
        end
        repeat (2)
            @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Empty tables
        do_lookup(32'hcafe_f00d);

        // Insert, find, insert again
        do_insert(32'h0000_0001);
        do_lookup(32'h0000_0001);
        do_insert(32'h0000_0001);

        // Three keys on bucket 0 of both tables
        do_insert(32'h0000_1010);
        do_insert(32'h0000_2020);
        do_insert(32'h0000_3030);
        do_lookup(32'h0000_3030);

        // Remove, then reuse the freed T1 bucket
        do_remove(32'h0000_1010);
        do_lookup(32'h0000_1010);
        do_remove(32'h0000_1010);
        do_insert(32'h0000_3030);
        do_lookup(32'h0000_2020);

        // Conflicting and ignored strobes leave the tables alone
        multi_strobe(32'h0000_0f00);
        do_lookup(32'h0000_0f00);
        strobe_while_busy(32'h0000_2020, 32'h0000_0e00);
        do_lookup(32'h0000_0e00);

        // Random mix over a small key pool
        for (int i = 0; i < 8; i++)
            pool[i] = $random(seed);
        for (int n = 0; n < 40; n++)
        begin
            pick = $unsigned($random(seed)) % 8;
            sel  = $unsigned($random(seed)) % 3;
            case (sel)
                0: do_insert(pool[pick]);
                1: do_lookup(pool[pick]);
                default: do_remove(pool[pick]);
            endcase
        end

        @(posedge clk);
        #2;
        if (i_dut.i_props.fail_cnt == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("A bound timing assertion failed");
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/classifier_pkg.sv
hdl/class_ctrl_fsm.sv
hdl/class_wait_timer.sv
hdl/class_hash.sv
hdl/class_bucket_mem.sv
hdl/class_key_comp.sv
hdl/classifier.sv
bench/classifier_props.sv
bench/classifier_tb.sv

// ==== Bender.yml ====
package:
  name: classifier

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/classifier_pkg.sv
      - hdl/class_ctrl_fsm.sv
      - hdl/class_wait_timer.sv
      - hdl/class_hash.sv
      - hdl/class_bucket_mem.sv
      - hdl/class_key_comp.sv
      - hdl/classifier.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/classifier_props.sv
      - bench/classifier_tb.sv
